// File: hdl/cache_geom_pkg.sv
`default_nettype none

// address split and index types shared by the controller, tag store and data array
package cache_geom_pkg;

   // a word is 16 bits so the lowest address bit selects the byte within it
   localparam int BYTE_BITS = 1;

   // eight words per block
   localparam int WORD_BITS = 3;

   // sixty-four sets
   localparam int SET_BITS = 6;

   // two blocks per set
   localparam int WAYS = 2;

   // bit positions of each address field counted from bit 0
   localparam int WORD_LSB = BYTE_BITS;
   localparam int SET_LSB = WORD_LSB + WORD_BITS;

   // the tag takes every address bit from here up to ADDR_WIDTH-1
   localparam int TAG_LSB = SET_LSB + SET_BITS;

   typedef logic [SET_BITS-1:0] set_t;

   typedef logic [WORD_BITS-1:0] word_sel_t;

   typedef logic [15:0] word_t;

   // data array index with the set on top so that both ways of a set sit next to each other
   typedef struct packed {
      set_t                      set;
      logic [$clog2(WAYS)-1:0]   way;
      word_sel_t                 word;
   } block_word_t;

endpackage

`default_nettype wire

// File: hdl/axil_pkg.sv
`default_nettype none

// channel bundles for the 16-bit AXI4-Lite ports on the processor and memory sides
package axil_pkg;

   // the struct address is full width and the cache uses only the low ADDR_WIDTH bits
   localparam int AXIL_ADDR_MAX = 32;

   // data width of both buses
   localparam int AXIL_DATA_BITS = 16;

   // read address channel
   typedef struct packed {
      logic [AXIL_ADDR_MAX-1:0]  addr;
      logic                      valid;
   } axil_ar_t;

   // read data channel
   // the response code is left out since every read answers OKAY
   typedef struct packed {
      logic [AXIL_DATA_BITS-1:0] data;
      logic                      valid;
   } axil_r_t;

   // write address channel
   typedef struct packed {
      logic [AXIL_ADDR_MAX-1:0]  addr;
      logic                      valid;
   } axil_aw_t;

   // write data channel
   // every write covers the whole word so there is no strobe
   typedef struct packed {
      logic [AXIL_DATA_BITS-1:0] data;
      logic                      valid;
   } axil_w_t;

   // ready signals and the write response valid travel as single wires

endpackage

`default_nettype wire

// File: hdl/cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

// single-port storage with a registered read
// the same block holds either metadata entries or data words
module cache_ram #(
   parameter type entry_t = logic [15:0],
   parameter int  DEPTH   = 1024
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire logic [$clog2(DEPTH)-1:0] idx,
   input  wire logic                     we,
   input  wire entry_t                   wdata,
   output entry_t                        rdata
);

   entry_t mem [DEPTH];

   // reset empties every entry which leaves all metadata valid bits at zero
   // a write and a read to the same index in one cycle return the old entry
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
         rdata <= '0;
      end else begin
         if (we) begin
            mem[idx] <= wdata;
         end
         // the array is read every cycle and the output follows idx one cycle later
         rdata <= mem[idx];
      end
   end

endmodule

`default_nettype wire

// File: hdl/cache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

// metadata for both ways with tag compare and LRU victim choice
module cache_tag_store import cache_geom_pkg::*; #(
   parameter int ADDR_WIDTH = 16
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic [ADDR_WIDTH-1:0] lookup_addr,
   input  wire logic                  upd,
   input  wire logic                  upd_way,
   output logic                       hit,
   output logic                       hit_way,
   output logic                       victim_way
);

   localparam int TAG_BITS = ADDR_WIDTH - TAG_LSB;

   // the LRU bit is only meaningful in way 0 and names the way to evict next
   typedef struct packed {
      logic                lru;
      logic                valid;
      logic [TAG_BITS-1:0] tag;
   } meta_t;

   logic [TAG_BITS-1:0] lookup_tag;
   set_t                lookup_set;
   meta_t               meta0_rd;
   meta_t               meta1_rd;
   meta_t               meta0_wr;
   meta_t               meta1_wr;
   logic [WAYS-1:0]     match;

   assign lookup_tag = lookup_addr[ADDR_WIDTH-1:TAG_LSB];
   assign lookup_set = lookup_addr[TAG_LSB-1:SET_LSB];

   // both ways are read every cycle at the set of the lookup address
   cache_ram #(
      .entry_t (meta_t),
      .DEPTH   (1 << SET_BITS)
   ) i_meta_way0 (
      .clk   (clk),
      .rst_n (rst_n),
      .idx   (lookup_set),
      .we    (upd),
      .wdata (meta0_wr),
      .rdata (meta0_rd)
   );

   cache_ram #(
      .entry_t (meta_t),
      .DEPTH   (1 << SET_BITS)
   ) i_meta_way1 (
      .clk   (clk),
      .rst_n (rst_n),
      .idx   (lookup_set),
      .we    (upd && upd_way),
      .wdata (meta1_wr),
      .rdata (meta1_rd)
   );

   // the controller holds the lookup address steady so the tag compared here
   // belongs to the set that was read in the previous cycle
   assign match[0] = meta0_rd.valid && (meta0_rd.tag == lookup_tag);
   assign match[1] = meta1_rd.valid && (meta1_rd.tag == lookup_tag);

   assign hit     = |match;
   assign hit_way = match[1];

   // LRU 0 evicts way 0 and LRU 1 evicts way 1
   assign victim_way = meta0_rd.lru;

   always_comb begin
      // the used way gets the tag with valid set
      meta1_wr = '{lru: 1'b0, valid: 1'b1, tag: lookup_tag};
      if (upd_way) begin
         // way 0 keeps its own tag and valid and only its LRU bit changes
         meta0_wr = '{lru: 1'b0, valid: meta0_rd.valid, tag: meta0_rd.tag};
      end else begin
         meta0_wr = '{lru: 1'b1, valid: 1'b1, tag: lookup_tag};
      end
   end

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// transaction FSM for lookup, block refill, write-through and both bus responses
module cache_ctrl import cache_geom_pkg::*, axil_pkg::*; #(
   parameter int ADDR_WIDTH = 16
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   // processor side
   input  wire axil_ar_t              s_ar,
   output logic                       s_ar_ready,
   output axil_r_t                    s_r,
   input  wire logic                  s_r_ready,
   input  wire axil_aw_t              s_aw,
   output logic                       s_aw_ready,
   input  wire axil_w_t               s_w,
   output logic                       s_w_ready,
   output logic                       s_b_valid,
   input  wire logic                  s_b_ready,
   // memory side
   output axil_ar_t                   m_ar,
   input  wire logic                  m_ar_ready,
   input  wire axil_r_t               m_r,
   output logic                       m_r_ready,
   output axil_aw_t                   m_aw,
   input  wire logic                  m_aw_ready,
   output axil_w_t                    m_w,
   input  wire logic                  m_w_ready,
   input  wire logic                  m_b_valid,
   output logic                       m_b_ready,
   // tag store
   output logic [ADDR_WIDTH-1:0]      lookup_addr,
   output logic                       upd,
   output logic                       upd_way,
   input  wire logic                  hit,
   input  wire logic                  hit_way,
   input  wire logic                  victim_way,
   // data array
   output block_word_t                data_idx,
   output logic                       data_we,
   output word_t                      data_wdata,
   input  wire word_t                 data_rdata,
   output logic                       miss
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_RESPOND,
      ST_REFILL_AR,
      ST_REFILL_R,
      ST_WR_MEM,
      ST_WR_RESP
   } state_t;

   state_t                  state;
   state_t                  state_nxt;
   logic                    is_wr;
   logic                    hit_q;
   logic                    way_q;
   logic                    from_refill;
   logic                    aw_done;
   logic                    w_done;
   word_sel_t               cnt;
   logic [ADDR_WIDTH-1:0]   req_addr;
   word_t                   wdata_q;
   word_t                   fill_word;
   logic                    wr_offer;
   logic                    wr_fire;
   logic                    ar_fire;
   logic                    r_fire;
   logic                    aw_fire;
   logic                    w_fire;
   logic                    b_fire;
   logic                    last_word;
   set_t                    req_set;
   word_sel_t               req_word;

   assign req_set  = req_addr[TAG_LSB-1:SET_LSB];
   assign req_word = req_addr[SET_LSB-1:WORD_LSB];

   // a write needs both address and data before it is taken and it wins over a read
   assign wr_offer   = s_aw.valid && s_w.valid;
   assign s_aw_ready = (state == ST_IDLE) && wr_offer;
   assign s_w_ready  = s_aw_ready;
   assign s_ar_ready = (state == ST_IDLE) && s_ar.valid && !wr_offer;
   assign wr_fire    = s_aw_ready;
   assign ar_fire    = s_ar_ready;

   assign s_r.valid = (state == ST_RESPOND);
   // a hit answers from the data array output which stays put while the index is held
   assign s_r.data  = from_refill ? fill_word : data_rdata;
   assign s_b_valid = (state == ST_WR_RESP);

   // refill reads walk the block from word 0 to word 7
   always_comb begin
      m_ar.addr = '0;
      m_ar.addr[ADDR_WIDTH-1:0] = {req_addr[ADDR_WIDTH-1:SET_LSB], cnt, {BYTE_BITS{1'b0}}};
      m_aw.addr = '0;
      m_aw.addr[ADDR_WIDTH-1:0] = req_addr;
   end

   assign m_ar.valid = (state == ST_REFILL_AR);
   assign m_r_ready  = (state == ST_REFILL_R);
   assign r_fire     = m_r_ready && m_r.valid;
   assign last_word  = &cnt;

   // address and data of the forwarded write may be taken in different cycles
   assign m_aw.valid = (state == ST_WR_MEM) && !aw_done;
   assign m_w.valid  = (state == ST_WR_MEM) && !w_done;
   assign m_w.data   = wdata_q;
   assign aw_fire    = m_aw.valid && m_aw_ready;
   assign w_fire     = m_w.valid && m_w_ready;
   assign m_b_ready  = (state == ST_WR_MEM) && aw_done && w_done;
   assign b_fire     = m_b_ready && m_b_valid;

   // in idle the incoming address goes straight to the tag store so that the
   // metadata read overlaps the handshake cycle
   always_comb begin
      lookup_addr = req_addr;
      if (state == ST_IDLE) begin
         lookup_addr = wr_offer ? s_aw.addr[ADDR_WIDTH-1:0] : s_ar.addr[ADDR_WIDTH-1:0];
      end
   end

   // the LRU moves on every hit and once more when a refill completes
   assign upd     = ((state == ST_LOOKUP) && hit) || (r_fire && last_word);
   assign upd_way = (state == ST_LOOKUP) ? hit_way : way_q;

   // the hit way is known during lookup and is held in way_q afterwards
   assign data_idx.set  = req_set;
   assign data_idx.way  = (state == ST_LOOKUP) ? hit_way : way_q;
   assign data_idx.word = (state == ST_REFILL_R) ? cnt : req_word;
   assign data_we       = r_fire || ((state == ST_WR_MEM) && hit_q);
   assign data_wdata    = (state == ST_REFILL_R) ? m_r.data : wdata_q;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:      if (wr_fire || ar_fire) state_nxt = ST_LOOKUP;
         ST_LOOKUP: begin
            if (is_wr) begin
               state_nxt = ST_WR_MEM;
            end else if (hit) begin
               state_nxt = ST_RESPOND;
            end else begin
               state_nxt = ST_REFILL_AR;
            end
         end
         ST_RESPOND:   if (s_r_ready) state_nxt = ST_IDLE;
         ST_REFILL_AR: if (m_ar_ready) state_nxt = ST_REFILL_R;
         ST_REFILL_R:  if (r_fire) state_nxt = last_word ? ST_RESPOND : ST_REFILL_AR;
         ST_WR_MEM:    if (b_fire) state_nxt = ST_WR_RESP;
         ST_WR_RESP:   if (s_b_ready) state_nxt = ST_IDLE;
         default:      state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= ST_IDLE;
         is_wr       <= 1'b0;
         hit_q       <= 1'b0;
         way_q       <= 1'b0;
         from_refill <= 1'b0;
         aw_done     <= 1'b0;
         w_done      <= 1'b0;
         cnt         <= '0;
         miss        <= 1'b0;
      end else begin
         state <= state_nxt;
         // miss is a single pulse in the cycle after a read lookup fails
         miss  <= (state == ST_LOOKUP) && !is_wr && !hit;
         if (state == ST_IDLE) begin
            is_wr <= wr_offer;
         end
         if (state == ST_LOOKUP) begin
            hit_q       <= hit;
            // on a miss the refill goes into the way that LRU points at
            way_q       <= hit ? hit_way : victim_way;
            from_refill <= 1'b0;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            cnt         <= '0;
         end
         if (r_fire) begin
            cnt <= cnt + word_sel_t'(1);
            if (last_word) begin
               from_refill <= 1'b1;
            end
         end
         if (aw_fire) begin
            aw_done <= 1'b1;
         end
         if (w_fire) begin
            w_done <= 1'b1;
         end
      end
   end

   // request address and data are captured at the handshake
   always_ff @(posedge clk) begin
      if (wr_fire) begin
         req_addr <= s_aw.addr[ADDR_WIDTH-1:0];
         wdata_q  <= s_w.data;
      end else if (ar_fire) begin
         req_addr <= s_ar.addr[ADDR_WIDTH-1:0];
      end
      // keep the requested word as it passes by during refill
      if (r_fire && (cnt == req_word)) begin
         fill_word <= m_r.data;
      end
   end

endmodule

`default_nettype wire

// File: hdl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

// two-way set-associative read cache with write-through between two AXI4-Lite ports
module cache_top import cache_geom_pkg::*, axil_pkg::*; #(
   parameter int ADDR_WIDTH = 16
) (
   input  wire logic     clk,
   input  wire logic     rst_n,
   // processor side slave
   input  wire axil_ar_t s_ar,
   output logic          s_ar_ready,
   output axil_r_t       s_r,
   input  wire logic     s_r_ready,
   input  wire axil_aw_t s_aw,
   output logic          s_aw_ready,
   input  wire axil_w_t  s_w,
   output logic          s_w_ready,
   output logic          s_b_valid,
   input  wire logic     s_b_ready,
   // memory side master
   output axil_ar_t      m_ar,
   input  wire logic     m_ar_ready,
   input  wire axil_r_t  m_r,
   output logic          m_r_ready,
   output axil_aw_t      m_aw,
   input  wire logic     m_aw_ready,
   output axil_w_t       m_w,
   input  wire logic     m_w_ready,
   input  wire logic     m_b_valid,
   output logic          m_b_ready,
   output logic          miss
);

   // one entry per word of every block in every way
   localparam int DATA_DEPTH = 1 << $bits(block_word_t);

   logic [ADDR_WIDTH-1:0] lookup_addr;
   logic                  upd;
   logic                  upd_way;
   logic                  hit;
   logic                  hit_way;
   logic                  victim_way;
   block_word_t           data_idx;
   logic                  data_we;
   word_t                 data_wdata;
   word_t                 data_rdata;

   cache_ctrl #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_cache_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .s_ar        (s_ar),
      .s_ar_ready  (s_ar_ready),
      .s_r         (s_r),
      .s_r_ready   (s_r_ready),
      .s_aw        (s_aw),
      .s_aw_ready  (s_aw_ready),
      .s_w         (s_w),
      .s_w_ready   (s_w_ready),
      .s_b_valid   (s_b_valid),
      .s_b_ready   (s_b_ready),
      .m_ar        (m_ar),
      .m_ar_ready  (m_ar_ready),
      .m_r         (m_r),
      .m_r_ready   (m_r_ready),
      .m_aw        (m_aw),
      .m_aw_ready  (m_aw_ready),
      .m_w         (m_w),
      .m_w_ready   (m_w_ready),
      .m_b_valid   (m_b_valid),
      .m_b_ready   (m_b_ready),
      .lookup_addr (lookup_addr),
      .upd         (upd),
      .upd_way     (upd_way),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim_way  (victim_way),
      .data_idx    (data_idx),
      .data_we     (data_we),
      .data_wdata  (data_wdata),
      .data_rdata  (data_rdata),
      .miss        (miss)
   );

   cache_tag_store #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) i_cache_tag_store (
      .clk         (clk),
      .rst_n       (rst_n),
      .lookup_addr (lookup_addr),
      .upd         (upd),
      .upd_way     (upd_way),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim_way  (victim_way)
   );

   // data words of both ways indexed by set, way and word
   cache_ram #(
      .entry_t (word_t),
      .DEPTH   (DATA_DEPTH)
   ) i_data_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .idx   (data_idx),
      .we    (data_we),
      .wdata (data_wdata),
      .rdata (data_rdata)
   );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock with a reset that is held low for the first few cycles
module tb_clock_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 3
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset is released on a falling edge so it never races the rising edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the cache with a memory model on the master side and a cache model
module tb_cache import axil_pkg::*;;
   localparam int ADDR_WIDTH  = 16;
   localparam int MAX_DELAY   = 3;
   localparam int NUM_RANDOM  = 400;
   // six cold reads, six hit reads, four write_through and six lru_evict transactions
   // run ahead of the random mix
   localparam int NUM_TXN     = 22 + NUM_RANDOM;
   localparam int CYCLE_LIMIT = NUM_TXN * (8 * MAX_DELAY + 20);

   logic clk, rst_n, miss;
   axil_ar_t s_ar, m_ar;
   axil_r_t s_r, m_r;
   axil_aw_t s_aw, m_aw;
   axil_w_t s_w, m_w;
   logic s_ar_ready, s_r_ready, s_aw_ready, s_w_ready, s_b_valid, s_b_ready;
   logic m_ar_ready, m_r_ready, m_aw_ready, m_w_ready, m_b_valid, m_b_ready;

   // memory contents as the memory holds them and as the test expects them
   logic [15:0] mem_img [32768];
   logic [15:0] ref_mem [32768];
   // cache model with one LRU bit per set naming the next victim
   logic [5:0] mdl_tag [64][2];
   logic mdl_valid [64][2];
   logic mdl_lru [64];

   logic [31:0] stim_seed, mem_seed;
   logic [15:0] rd_log [$];
   logic [15:0] last_wr_addr, last_wr_data;
   int wr_count, miss_cnt, cycles;
   int tag_pool [4] = '{3, 17, 40, 63};
   int set_pool [3] = '{2, 9, 33};

   tb_clock_gen #(.PERIOD(20), .RST_CYCLES(3)) i_clock_gen (.clk(clk), .rst_n(rst_n));

   cache_top #(.ADDR_WIDTH(ADDR_WIDTH)) i_cache_top (
      .clk(clk), .rst_n(rst_n),
      .s_ar(s_ar), .s_ar_ready(s_ar_ready), .s_r(s_r), .s_r_ready(s_r_ready),
      .s_aw(s_aw), .s_aw_ready(s_aw_ready), .s_w(s_w), .s_w_ready(s_w_ready),
      .s_b_valid(s_b_valid), .s_b_ready(s_b_ready),
      .m_ar(m_ar), .m_ar_ready(m_ar_ready), .m_r(m_r), .m_r_ready(m_r_ready),
      .m_aw(m_aw), .m_aw_ready(m_aw_ready), .m_w(m_w), .m_w_ready(m_w_ready),
      .m_b_valid(m_b_valid), .m_b_ready(m_b_ready), .miss(miss)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int draw_stim(input int range);
      stim_seed = lcg_next(stim_seed);
      return int'(stim_seed[30:16]) % range;
   endfunction

   function automatic logic [15:0] draw_word();
      stim_seed = lcg_next(stim_seed);
      return stim_seed[31:16];
   endfunction

   function automatic int mem_delay();
      mem_seed = lcg_next(mem_seed);
      return int'(mem_seed[29:16]) % (MAX_DELAY + 1);
   endfunction

   // every bit of the word index takes part in the fill value
   function automatic logic [15:0] fill_value(input int idx);
      return 16'(idx * 40503) ^ 16'h3c5a ^ 16'(idx >> 7);
   endfunction

   function automatic logic [15:0] make_addr(input int tag, input int set, input int word);
      return {6'(tag), 6'(set), 3'(word), 1'b0};
   endfunction

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp == act) else begin
         $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
         $display("tests failed");
         $fatal(1);
      end
   endtask

   // looks the address up in the model, applies the LRU and refill rules and returns the hit
   function automatic bit model_access(input logic [15:0] addr, input bit is_read);
      bit hit_exp;
      int set;
      int way;
      set = int'(addr[9:4]);
      hit_exp = 1'b0;
      way = 0;
      for (int w = 0; w < 2; w++) begin
         if (mdl_valid[set][w] && mdl_tag[set][w] == addr[15:10]) begin
            hit_exp = 1'b1;
            way = w;
         end
      end
      if (!hit_exp && is_read) begin
         way = int'(mdl_lru[set]);
         mdl_tag[set][way] = addr[15:10];
         mdl_valid[set][way] = 1'b1;
      end
      // the LRU bit then points at the way that was not used
      if (hit_exp || is_read) mdl_lru[set] = (way == 0);
      return hit_exp;
   endfunction

   // ready on the processor side is combinational so it is sampled after a short settle
   task automatic wait_accept(input string name, input bit is_wr);
      #2;
      while (!(is_wr ? s_aw_ready : s_ar_ready)) begin
         @(negedge clk);
         #2;
      end
      // write address and write data are taken in the same cycle
      if (is_wr) check_value({name, " write data ready"}, 1, s_w_ready);
      @(posedge clk);
   endtask

   // holds the response for a random time and checks that it stays offered until taken
   task automatic release_response(input string name, input bit bp, input bit is_wr,
                                   input logic [15:0] exp_data);
      int n;
      n = bp ? draw_stim(MAX_DELAY + 1) : 0;
      repeat (n) begin
         @(negedge clk);
         if (is_wr) begin
            check_value({name, " held write response"}, 1, s_b_valid);
         end else begin
            check_value({name, " held read valid"}, 1, s_r.valid);
            check_value({name, " held read data"}, exp_data, s_r.data);
         end
      end
      if (is_wr) s_b_ready = 1'b1;
      else s_r_ready = 1'b1;
      @(negedge clk);
      s_r_ready = 1'b0;
      s_b_ready = 1'b0;
   endtask

   task automatic do_read(input string name, input logic [15:0] addr, input bit bp);
      bit hit_exp;
      int lat;
      int miss0;
      logic [15:0] base;
      hit_exp = model_access(addr, 1'b1);
      rd_log.delete();
      miss0 = miss_cnt;
      base = {addr[15:4], 4'h0};
      @(negedge clk);
      s_ar.addr = {16'h0, addr};
      s_ar.valid = 1'b1;
      wait_accept(name, 1'b0);
      @(negedge clk);
      s_ar.valid = 1'b0;
      lat = 1;
      while (!s_r.valid) begin
         @(negedge clk);
         lat++;
      end
      if (hit_exp) check_value({name, " latency"}, 2, lat);
      check_value({name, " data"}, ref_mem[addr[15:1]], s_r.data);
      release_response(name, bp, 1'b0, ref_mem[addr[15:1]]);
      check_value({name, " memory reads"}, hit_exp ? 0 : 8, rd_log.size());
      check_value({name, " miss pulses"}, hit_exp ? 0 : 1, miss_cnt - miss0);
      foreach (rd_log[i]) check_value({name, " refill address"}, base + 16'(2 * i), rd_log[i]);
   endtask

   task automatic do_write(input string name, input logic [15:0] addr, input logic [15:0] data,
                           input bit bp);
      int wr0;
      int miss0;
      void'(model_access(addr, 1'b0));
      ref_mem[addr[15:1]] = data;
      rd_log.delete();
      wr0 = wr_count;
      miss0 = miss_cnt;
      @(negedge clk);
      s_aw.addr = {16'h0, addr};
      s_aw.valid = 1'b1;
      s_w.data = data;
      s_w.valid = 1'b1;
      wait_accept(name, 1'b1);
      @(negedge clk);
      s_aw.valid = 1'b0;
      s_w.valid = 1'b0;
      while (!s_b_valid) @(negedge clk);
      release_response(name, bp, 1'b1, 16'h0);
      check_value({name, " memory writes"}, 1, wr_count - wr0);
      check_value({name, " write address"}, addr, last_wr_addr);
      check_value({name, " write data"}, data, last_wr_data);
      check_value({name, " memory reads"}, 0, rd_log.size());
      check_value({name, " miss pulses"}, 0, miss_cnt - miss0);
   endtask

   // memory slave answering one request at a time after random delays
   task automatic serve_read();
      logic [15:0] addr;
      repeat (mem_delay()) @(negedge clk);
      m_ar_ready = 1'b1;
      addr = m_ar.addr[15:0];
      @(negedge clk);
      m_ar_ready = 1'b0;
      rd_log.push_back(addr);
      repeat (mem_delay()) @(negedge clk);
      m_r.data = mem_img[addr[15:1]];
      m_r.valid = 1'b1;
      @(negedge clk);
      m_r.valid = 1'b0;
   endtask

   task automatic serve_write();
      repeat (mem_delay()) @(negedge clk);
      m_aw_ready = 1'b1;
      m_w_ready = 1'b1;
      last_wr_addr = m_aw.addr[15:0];
      last_wr_data = m_w.data;
      @(negedge clk);
      m_aw_ready = 1'b0;
      m_w_ready = 1'b0;
      mem_img[last_wr_addr[15:1]] = last_wr_data;
      wr_count++;
      repeat (mem_delay()) @(negedge clk);
      m_b_valid = 1'b1;
      @(negedge clk);
      m_b_valid = 1'b0;
   endtask

   initial begin
      @(posedge rst_n);
      forever begin
         @(negedge clk);
         if (m_ar.valid) serve_read();
         else if (m_aw.valid && m_w.valid) serve_write();
      end
   end

   always @(negedge clk) begin
      if (rst_n && miss) miss_cnt++;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) stop_with_failure("timeout: the run went past its cycle limit");
   end

   initial begin
      s_ar = '0;
      s_aw = '0;
      s_w = '0;
      m_r = '0;
      s_r_ready = 1'b0;
      s_b_ready = 1'b0;
      m_ar_ready = 1'b0;
      m_aw_ready = 1'b0;
      m_w_ready = 1'b0;
      m_b_valid = 1'b0;
      stim_seed = 32'h38a0;
      mem_seed = 32'h38a0;
      wr_count = 0;
      miss_cnt = 0;
      cycles = 0;
      for (int i = 0; i < 32768; i++) begin
         mem_img[i] = fill_value(i);
         ref_mem[i] = fill_value(i);
      end
      for (int s = 0; s < 64; s++) begin
         mdl_valid[s][0] = 1'b0;
         mdl_valid[s][1] = 1'b0;
         mdl_lru[s] = 1'b0;
      end
      @(posedge rst_n);
      @(negedge clk);
      check_value("reset outputs", 0, {s_r.valid, s_b_valid, s_ar_ready, s_aw_ready, s_w_ready,
                  m_ar.valid, m_aw.valid, m_w.valid, m_r_ready, m_b_ready, miss});
      for (int i = 0; i < 6; i++) begin
         do_read("cold_read", make_addr(tag_pool[i % 4], set_pool[i % 3], i), 1'b0);
      end
      for (int i = 0; i < 6; i++) begin
         do_read("hit_read", make_addr(tag_pool[i % 4], set_pool[i % 3], i + 3), 1'b0);
      end
      // one write to a resident block and one to a block that is not cached
      do_write("write_through", make_addr(3, 2, 5), 16'hbeef, 1'b0);
      do_write("write_through", make_addr(40, 2, 1), 16'h1234, 1'b0);
      do_read("write_through", make_addr(3, 2, 5), 1'b0);
      do_read("write_through", make_addr(40, 2, 1), 1'b0);
      // three tags in one set force an eviction chosen by the LRU bit
      do_read("lru_evict", make_addr(5, 20, 0), 1'b0);
      do_read("lru_evict", make_addr(6, 20, 1), 1'b0);
      do_read("lru_evict", make_addr(5, 20, 2), 1'b0);
      do_read("lru_evict", make_addr(7, 20, 3), 1'b0);
      do_read("lru_evict", make_addr(5, 20, 4), 1'b0);
      do_read("lru_evict", make_addr(6, 20, 5), 1'b0);
      for (int n = 0; n < NUM_RANDOM; n++) begin
         logic [15:0] addr;
         addr = make_addr(tag_pool[draw_stim(4)], set_pool[draw_stim(3)], draw_stim(8));
         if (draw_stim(10) < 3) do_write("random_mix", addr, draw_word(), 1'b1);
         else do_read("random_mix", addr, 1'b1);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
hdl/cache_geom_pkg.sv
hdl/axil_pkg.sv
hdl/cache_ram.sv
hdl/cache_tag_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cache.sv

// File: run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it
# the exit status is the simulator's, nonzero when the testbench stops with $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cache -f sim.f -o tb_cache_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_cache_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi

exit 0
